// ==== rtl/sid_pkg.sv ====
package sid_pkg;

    // ========================================
    // Widths and constants
    // ========================================

    // Frequency register and phase accumulator
    localparam int FREQ_W      = 16;
    // Generic register byte, LFSR and sample
    localparam int BYTE_W      = 8;
    localparam int ENV_W       = 4;
    // Shared envelope prescaler
    localparam int PRESC_W     = 23;
    // Waveform times envelope
    localparam int VOICE_OUT_W = 12;
    localparam int MIX_W       = 10;
    // Voice index on the bus and in the sequencer
    localparam int SLOT_W      = 2;

    localparam logic [BYTE_W-1:0] LFSR_SEED = 8'h01;

    // Bit positions inside the waveform control byte
    localparam int WF_GATE  = 0;
    localparam int WF_TEST  = 3;
    localparam int WF_TRI   = 4;
    localparam int WF_SAW   = 5;
    localparam int WF_PULSE = 6;
    localparam int WF_NOISE = 7;

    // ========================================
    // Enums and structs
    // ========================================

    // Per-voice register map, addresses 3 and 7 unused
    typedef enum logic [2:0] {
        FREQ_LO  = 3'd0,
        FREQ_HI  = 3'd1,
        PULSE_W  = 3'd2,
        ATTACK   = 3'd4,
        SUSTAIN  = 3'd5,
        WAVEFORM = 3'd6
    } reg_addr_e;

    typedef enum logic [1:0] {
        ENV_IDLE,
        ENV_ATTACK,
        ENV_DECAY,
        ENV_RELEASE
    } env_state_e;

    // Register write bus, write fires on rising wr_en
    typedef struct packed {
        logic              wr_en;
        logic [SLOT_W-1:0] voice;
        reg_addr_e         addr;
        logic [BYTE_W-1:0] data;
    } reg_wr_t;

    // One voice's configuration
    typedef struct packed {
        logic [FREQ_W-1:0] freq;
        logic [BYTE_W-1:0] pulse_w;
        // Decay rate high nibble, attack rate low nibble
        logic [BYTE_W-1:0] attack;
        // Release rate high nibble, sustain level low nibble
        logic [BYTE_W-1:0] sustain;
        logic [BYTE_W-1:0] waveform;
    } voice_cfg_t;

    // One voice's running state
    typedef struct packed {
        logic [FREQ_W-1:0] acc;
        logic [BYTE_W-1:0] lfsr;
        logic [ENV_W-1:0]  env;
        env_state_e        env_state;
        logic              last_gate;
    } voice_state_t;

endpackage

// ==== rtl/sid_reg_bank.sv ====
`timescale 1ns/10ps

module sid_reg_bank #(
    parameter int NUM_VOICES = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  sid_pkg::reg_wr_t    reg_wr,
    output sid_pkg::voice_cfg_t cfg [NUM_VOICES]
);
    import sid_pkg::*;

    // ========================================
    // Write strobe edge detect
    // ========================================

    logic wr_en_d;
    logic wr_rise;

    // Previous level of the write enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_d <= 1'b0;
        end else begin
            wr_en_d <= reg_wr.wr_en;
        end
    end

    // One write per low-to-high transition
    assign wr_rise = reg_wr.wr_en && !wr_en_d;

    // ========================================
    // Per-voice configuration registers
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                cfg[v] <= '0;
            end
        end else if (wr_rise) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                // Voice numbers past the last voice never match
                if (reg_wr.voice == SLOT_W'(v)) begin
                    case (reg_wr.addr)
                        FREQ_LO:  cfg[v].freq[7:0]  <= reg_wr.data;
                        FREQ_HI:  cfg[v].freq[15:8] <= reg_wr.data;
                        PULSE_W:  cfg[v].pulse_w    <= reg_wr.data;
                        ATTACK:   cfg[v].attack     <= reg_wr.data;
                        SUSTAIN:  cfg[v].sustain    <= reg_wr.data;
                        WAVEFORM: cfg[v].waveform   <= reg_wr.data;
                        // Unmapped addresses are dropped
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// ==== rtl/sid_envelope.sv ====
`timescale 1ns/10ps

module sid_envelope (
    input  sid_pkg::voice_state_t         state,
    input  sid_pkg::voice_cfg_t           cfg,
    input  logic [sid_pkg::PRESC_W-1:0]   presc,
    output logic [sid_pkg::ENV_W-1:0]     next_env,
    output sid_pkg::env_state_e           next_env_state
);
    import sid_pkg::*;

    logic [3:0]         rate;
    logic [4:0]         tick_len;
    logic [PRESC_W-1:0] tick_mask;
    logic               tick;
    logic               gate;
    logic               gate_rise;
    logic [ENV_W-1:0]   sustain_lvl;

    assign gate        = cfg.waveform[WF_GATE];
    assign gate_rise   = gate && !state.last_gate;
    assign sustain_lvl = cfg.sustain[3:0];

    // ========================================
    // Rate select and tick decode
    // ========================================

    always_comb begin
        case (state.env_state)
            ENV_ATTACK:  rate = cfg.attack[3:0];
            ENV_DECAY:   rate = cfg.attack[7:4];
            ENV_RELEASE: rate = cfg.sustain[7:4];
            default:     rate = 4'd0;
        endcase
    end

    // Tick needs the low 9+rate prescaler bits set
    always_comb begin
        tick_len = 5'd9 + {1'b0, rate};
        // Rates 14 and 15 both use the full prescaler
        if (tick_len > 5'(PRESC_W)) begin
            tick_len = 5'(PRESC_W);
        end
        tick_mask = ~({PRESC_W{1'b1}} << tick_len);
        tick      = &(presc | ~tick_mask);
    end

    // ========================================
    // Next envelope state
    // ========================================

    always_comb begin
        next_env       = state.env;
        next_env_state = state.env_state;
        case (state.env_state)
            ENV_IDLE: begin
                next_env = '0;
                if (gate_rise) begin
                    next_env_state = ENV_ATTACK;
                end
            end
            ENV_ATTACK: begin
                if (!gate) begin
                    next_env_state = ENV_RELEASE;
                end else if (state.env == '1) begin
                    next_env_state = ENV_DECAY;
                end else if (tick) begin
                    next_env = state.env + 1'b1;
                end
            end
            ENV_DECAY: begin
                if (!gate) begin
                    next_env_state = ENV_RELEASE;
                end else if (state.env > sustain_lvl && tick) begin
                    // Falls toward sustain and parks there
                    next_env = state.env - 1'b1;
                end
            end
            default: begin
                // Release, a fresh gate retriggers attack
                if (gate_rise) begin
                    next_env_state = ENV_ATTACK;
                end else if (state.env == '0) begin
                    next_env_state = ENV_IDLE;
                end else if (tick) begin
                    next_env = state.env - 1'b1;
                end
            end
        endcase
    end

endmodule

// ==== rtl/sid_voice_engine.sv ====
`timescale 1ns/10ps

module sid_voice_engine #(
    parameter int NUM_VOICES = 3
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  sid_pkg::voice_cfg_t           cfg [NUM_VOICES],
    output logic [sid_pkg::BYTE_W-1:0]    voice_val,
    output logic [sid_pkg::SLOT_W-1:0]    slot
);
    import sid_pkg::*;

    localparam voice_state_t STATE_RST = '{
        acc:       '0,
        lfsr:      LFSR_SEED,
        env:       '0,
        env_state: ENV_IDLE,
        last_gate: 1'b0
    };

    logic [PRESC_W-1:0]     presc;
    voice_state_t           state [NUM_VOICES];
    voice_state_t           cur;
    voice_cfg_t             cur_cfg;
    voice_state_t           nxt;
    logic [ENV_W-1:0]       nxt_env;
    env_state_e             nxt_env_state;
    logic [BYTE_W-1:0]      tri_wave;
    logic [BYTE_W-1:0]      wave;
    logic [VOICE_OUT_W-1:0] scaled;
    logic                   test;

    // ========================================
    // Sequencer and shared prescaler
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot  <= '0;
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
            // Round robin over the voices
            if (slot == SLOT_W'(NUM_VOICES - 1)) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // Current voice view
    assign cur     = state[slot];
    assign cur_cfg = cfg[slot];
    assign test    = cur_cfg.waveform[WF_TEST];

    // ========================================
    // Waveform mix and envelope scaling
    // ========================================

    // Triangle folds on the top phase bit, saw enabled cancels the fold
    assign tri_wave = cur.acc[14:7] ^
                      (cur_cfg.waveform[WF_SAW] ? '0 : {BYTE_W{cur.acc[15]}});

    always_comb begin
        wave = '0;
        if (cur_cfg.waveform[WF_TRI])   wave = wave | tri_wave;
        if (cur_cfg.waveform[WF_SAW])   wave = wave | cur.acc[15:8];
        if (cur_cfg.waveform[WF_PULSE]) wave = wave | {BYTE_W{cur.acc[15:8] > cur_cfg.pulse_w}};
        if (cur_cfg.waveform[WF_NOISE]) wave = wave | cur.lfsr;
        scaled = wave * cur.env;
    end

    // Upper byte of the product
    assign voice_val = scaled[VOICE_OUT_W-1 -: BYTE_W];

    // ========================================
    // Next state of the current voice
    // ========================================

    sid_envelope env_i (
        .state          (cur),
        .cfg            (cur_cfg),
        .presc          (presc),
        .next_env       (nxt_env),
        .next_env_state (nxt_env_state)
    );

    always_comb begin
        // Test bit holds phase and noise at their seeds
        nxt.acc       = test ? '0 : cur.acc + cur_cfg.freq;
        nxt.lfsr      = test ? LFSR_SEED : {cur.lfsr[6:0], cur.lfsr[3] ^ cur.lfsr[7]};
        nxt.env       = nxt_env;
        nxt.env_state = nxt_env_state;
        nxt.last_gate = cur_cfg.waveform[WF_GATE];
    end

    // Only the voice in its slot advances
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                state[v] <= STATE_RST;
            end
        end else begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (slot == SLOT_W'(v)) begin
                    state[v] <= nxt;
                end
            end
        end
    end

endmodule

// ==== rtl/sid_mixer.sv ====
`timescale 1ns/10ps

module sid_mixer #(
    parameter int NUM_VOICES = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [sid_pkg::BYTE_W-1:0]  voice_val,
    input  logic [sid_pkg::SLOT_W-1:0]  slot,
    output logic [sid_pkg::BYTE_W-1:0]  sample
);
    import sid_pkg::*;

    logic [MIX_W-1:0] mix_acc;

    // Slot 0 closes the previous round and opens the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mix_acc <= '0;
            sample  <= '0;
        end else if (slot == '0) begin
            // Sum over the round divided by four
            sample  <= mix_acc[MIX_W-1:2];
            mix_acc <= MIX_W'(voice_val);
        end else begin
            mix_acc <= mix_acc + MIX_W'(voice_val);
        end
    end

endmodule

// ==== rtl/sid_pwm.sv ====
`timescale 1ns/10ps

module sid_pwm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [sid_pkg::BYTE_W-1:0]  sample,
    output logic                        pwm
);
    import sid_pkg::*;

    logic [BYTE_W-1:0] pwm_cnt;

    // Free-running ramp, period of 256 clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // High for sample clocks out of every 256
    assign pwm = pwm_cnt < sample;

endmodule

// ==== rtl/sid_top.sv ====
`timescale 1ns/10ps

module sid_top #(
    parameter int NUM_VOICES = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  sid_pkg::reg_wr_t            reg_wr,
    output logic [sid_pkg::BYTE_W-1:0]  sample,
    output logic                        pwm
);
    import sid_pkg::*;

    voice_cfg_t        cfg [NUM_VOICES];
    logic [BYTE_W-1:0] voice_val;
    logic [SLOT_W-1:0] slot;

    // ========================================
    // Register bank and voice engine
    // ========================================

    sid_reg_bank #(
        .NUM_VOICES (NUM_VOICES)
    ) reg_bank_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .reg_wr (reg_wr),
        .cfg    (cfg)
    );

    // One scaled voice per clock
    sid_voice_engine #(
        .NUM_VOICES (NUM_VOICES)
    ) engine_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .voice_val (voice_val),
        .slot      (slot)
    );

    // ========================================
    // Mixer and audio output
    // ========================================

    sid_mixer #(
        .NUM_VOICES (NUM_VOICES)
    ) mixer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .voice_val (voice_val),
        .slot      (slot),
        .sample    (sample)
    );

    sid_pwm pwm_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .pwm    (pwm)
    );

endmodule

// ==== tests/sid_tb.sv ====
`timescale 1ns/10ps

module sid_tb;
    import sid_pkg::*;

    localparam int NV          = 3;
    localparam int T1_CYC      = 300;
    localparam int T2_CYC      = 2000;
    localparam int T3_ON_CYC   = 30000;
    localparam int T3_OFF_CYC  = 26000;
    localparam int T4_CYC      = 5700;
    localparam int T5_MAX_CYC  = 30000;
    // Writes, settling and the PWM window
    localparam int MARGIN_CYC  = 6000;
    localparam int TOTAL_CYC   = T1_CYC + T2_CYC + T3_ON_CYC + T3_OFF_CYC + T4_CYC
                                 + T5_MAX_CYC + MARGIN_CYC;

    logic              clk = 1'b0;
    logic              rst_n;
    reg_wr_t           reg_wr;
    logic [BYTE_W-1:0] sample;
    logic              pwm;

    // Reference model state
    voice_cfg_t         m_cfg [NV];
    voice_state_t       m_st [NV];
    logic [PRESC_W-1:0] m_presc;
    logic [1:0]         m_slot;
    logic [MIX_W-1:0]   m_acc;
    logic [BYTE_W-1:0]  m_sample;
    logic [BYTE_W-1:0]  m_val;
    logic               m_wr_d;

    logic [31:0] rng;
    int          err_cnt;
    int          cmp_err_cnt;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;

    sid_top #(
        .NUM_VOICES (NV)
    ) dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .reg_wr (reg_wr),
        .sample (sample),
        .pwm    (pwm)
    );

    always #4 clk = ~clk;

    // ========================================
    // Reference model
    // ========================================

    // One voice step, next state returned and scaled output in val
    function automatic voice_state_t voice_step(input voice_state_t s, input voice_cfg_t c,
                                                input logic [PRESC_W-1:0] p,
                                                output logic [BYTE_W-1:0] val);
        voice_state_t n;
        logic [7:0]   w;
        logic [7:0]   hi;
        logic [11:0]  prod;
        logic [3:0]   rate;
        int           bits;
        logic         tick;
        logic         gate;
        logic         rise;
        n    = s;
        gate = c.waveform[0];
        rise = gate && !s.last_gate;
        hi   = s.acc[15:8];
        w    = 8'h00;
        // Triangle fold is suppressed when saw is on too
        if (c.waveform[4]) w = w | (s.acc[14:7] ^ ((s.acc[15] && !c.waveform[5]) ? 8'hff : 8'h00));
        if (c.waveform[5]) w = w | hi;
        if (c.waveform[6] && hi > c.pulse_w) w = 8'hff;
        if (c.waveform[7]) w = w | s.lfsr;
        prod = 12'(w) * 12'(s.env);
        val  = prod[11:4];
        case (s.env_state)
            ENV_ATTACK:  rate = c.attack[3:0];
            ENV_DECAY:   rate = c.attack[7:4];
            ENV_RELEASE: rate = c.sustain[7:4];
            default:     rate = 4'd0;
        endcase
        bits = 9 + int'(rate);
        if (bits > PRESC_W) bits = PRESC_W;
        // Low bits all ones means the next count clears them
        tick = ((int'(p) + 1) % (1 << bits)) == 0;
        case (s.env_state)
            ENV_IDLE: begin
                n.env = 4'd0;
                if (rise) n.env_state = ENV_ATTACK;
            end
            ENV_ATTACK: begin
                if (!gate) n.env_state = ENV_RELEASE;
                else if (s.env == 4'd15) n.env_state = ENV_DECAY;
                else if (tick) n.env = s.env + 4'd1;
            end
            ENV_DECAY: begin
                if (!gate) n.env_state = ENV_RELEASE;
                else if (tick && s.env > c.sustain[3:0]) n.env = s.env - 4'd1;
            end
            default: begin
                if (rise) n.env_state = ENV_ATTACK;
                else if (s.env == 4'd0) n.env_state = ENV_IDLE;
                else if (tick) n.env = s.env - 4'd1;
            end
        endcase
        if (c.waveform[3]) begin
            n.acc  = 16'h0000;
            n.lfsr = LFSR_SEED;
        end else begin
            n.acc  = s.acc + c.freq;
            n.lfsr = {s.lfsr[6:0], s.lfsr[3] ^ s.lfsr[7]};
        end
        n.last_gate = gate;
        return n;
    endfunction

    // Engine step with the old config, then mixer, then register write
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < NV; v++) begin
                m_cfg[v] = '0;
                m_st[v]  = '{acc: '0, lfsr: LFSR_SEED, env: '0, env_state: ENV_IDLE,
                             last_gate: 1'b0};
            end
            m_presc  = '0;
            m_slot   = 2'd0;
            m_acc    = '0;
            m_sample = '0;
            m_wr_d   = 1'b0;
        end else begin
            m_st[m_slot] = voice_step(m_st[m_slot], m_cfg[m_slot], m_presc, m_val);
            if (m_slot == 2'd0) begin
                m_sample = m_acc[9:2];
                m_acc    = MIX_W'(m_val);
            end else begin
                m_acc = m_acc + MIX_W'(m_val);
            end
            m_presc = m_presc + 1'b1;
            m_slot  = (m_slot == 2'(NV - 1)) ? 2'd0 : m_slot + 2'd1;
            if (reg_wr.wr_en && !m_wr_d && reg_wr.voice < 2'(NV)) begin
                case (reg_wr.addr)
                    FREQ_LO:  m_cfg[reg_wr.voice].freq[7:0]  = reg_wr.data;
                    FREQ_HI:  m_cfg[reg_wr.voice].freq[15:8] = reg_wr.data;
                    PULSE_W:  m_cfg[reg_wr.voice].pulse_w    = reg_wr.data;
                    ATTACK:   m_cfg[reg_wr.voice].attack     = reg_wr.data;
                    SUSTAIN:  m_cfg[reg_wr.voice].sustain    = reg_wr.data;
                    WAVEFORM: m_cfg[reg_wr.voice].waveform   = reg_wr.data;
                    default: ;
                endcase
            end
            m_wr_d = reg_wr.wr_en;
        end
    end

    // Sample comparison at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (sample !== m_sample) begin
                cmp_err_cnt++;
                $display("[ERROR] %0t: sample expected %0d, seen %0d", $time, m_sample, sample);
            end
        end
    end

    // ========================================
    // Stimulus helpers
    // ========================================

    function automatic logic [7:0] rand_byte();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng[31:24];
    endfunction

    task automatic reg_write(input logic [1:0] voice, input logic [2:0] addr,
                             input logic [7:0] data);
        @(posedge clk);
        #1;
        reg_wr.wr_en = 1'b1;
        reg_wr.voice = voice;
        reg_wr.addr  = reg_addr_e'(addr);
        reg_wr.data  = data;
        @(posedge clk);
        #1;
        reg_wr.wr_en = 1'b0;
    endtask

    // Enable stays high while the data keeps changing
    task automatic reg_write_held(input logic [1:0] voice, input logic [2:0] addr,
                                  input logic [7:0] data, input int hold);
        @(posedge clk);
        #1;
        reg_wr.wr_en = 1'b1;
        reg_wr.voice = voice;
        reg_wr.addr  = reg_addr_e'(addr);
        reg_wr.data  = data;
        repeat (hold) begin
            @(posedge clk);
            #1;
            reg_wr.data = rand_byte();
        end
        reg_wr.wr_en = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = err_cnt + cmp_err_cnt - err_mark;
        if (errs == 0) begin
            pass_cnt++;
            $display("%s: passed", name);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", name, errs);
        end
        err_mark = err_cnt + cmp_err_cnt;
    endtask

    // ========================================
    // Tests
    // ========================================

    initial begin
        logic [7:0] peak;
        int         n;
        int         high;
        rst_n       = 1'b0;
        reg_wr      = '0;
        rng         = 32'hee2d_17cc;
        err_cnt     = 0;
        cmp_err_cnt = 0;
        err_mark    = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Outputs idle straight out of reset
        repeat (T1_CYC) begin
            @(negedge clk);
            if (sample !== 8'd0 || pwm !== 1'b0) begin
                err_cnt++;
                $display("[ERROR] %0t: output not idle, sample %0d pwm %0b", $time, sample, pwm);
            end
        end
        finish_test("reset state");

        // All waveforms on, gate off, env held at 0
        for (int v = 0; v < NV; v++) begin
            reg_write(2'(v), FREQ_LO, rand_byte());
            reg_write(2'(v), FREQ_HI, rand_byte());
            reg_write(2'(v), WAVEFORM, 8'hf0);
        end
        repeat (T2_CYC) begin
            @(negedge clk);
            if (sample !== 8'd0) begin
                err_cnt++;
                $display("[ERROR] %0t: sample expected 0 with gate off, seen %0d", $time, sample);
            end
        end
        finish_test("gate off");

        // Saw, triangle and pulse voices through attack, decay and release
        for (int v = 0; v < NV; v++) begin
            reg_write(2'(v), ATTACK, 8'h00);
            reg_write(2'(v), SUSTAIN, v == 0 ? 8'h0f : (v == 1 ? 8'h08 : 8'h00));
            reg_write(2'(v), FREQ_LO, rand_byte());
            reg_write(2'(v), FREQ_HI, rand_byte());
            reg_write(2'(v), PULSE_W, rand_byte());
            reg_write(2'(v), WAVEFORM, v == 0 ? 8'h21 : (v == 1 ? 8'h11 : 8'h41));
        end
        peak = 8'd0;
        repeat (T3_ON_CYC) begin
            @(negedge clk);
            if (m_sample > peak) peak = m_sample;
        end
        for (int v = 0; v < NV; v++) begin
            reg_write(2'(v), WAVEFORM, v == 0 ? 8'h20 : (v == 1 ? 8'h10 : 8'h40));
        end
        repeat (T3_OFF_CYC) @(negedge clk);
        if (peak == 8'd0) begin
            err_cnt++;
            $display("Envelope test produced no output at all while the gates were on");
        end
        if (sample !== 8'd0) begin
            err_cnt++;
            $display("[ERROR] %0t: sample expected 0 after release, seen %0d", $time, sample);
        end
        finish_test("envelope and waveforms");

        // Noise with the test bit, held write, ignored writes
        reg_write(2'd0, WAVEFORM, 8'h81);
        repeat (3000) @(posedge clk);
        reg_write(2'd0, WAVEFORM, 8'h89);
        repeat (200) @(posedge clk);
        // Saw on top of noise so phase and frequency show in the sample
        reg_write(2'd0, WAVEFORM, 8'ha1);
        repeat (1000) @(posedge clk);
        reg_write_held(2'd0, FREQ_HI, 8'h5a, 6);
        reg_write(2'd0, 3'd3, 8'hff);
        reg_write(2'd0, 3'd7, 8'hff);
        reg_write(2'd3, WAVEFORM, 8'h00);
        repeat (1500) @(posedge clk);
        finish_test("noise, test bit and writes");

        // Test bit with triangle only keeps every voice at 0
        for (int v = 0; v < NV; v++) begin
            reg_write(2'(v), WAVEFORM, 8'h18);
        end
        repeat (20) @(negedge clk);
        repeat (100) begin
            @(negedge clk);
            if (sample !== 8'd0) begin
                err_cnt++;
                $display("[ERROR] %0t: sample expected 0 under test bit, seen %0d", $time, sample);
            end
        end
        // Phase set by a short run, then frozen with frequency 0
        for (int v = 0; v < NV; v++) begin
            reg_write(2'(v), SUSTAIN, 8'h0f);
            reg_write(2'(v), FREQ_LO, 8'h00);
            reg_write(2'(v), FREQ_HI, 8'h23 + 8'(v * 16));
            reg_write(2'(v), WAVEFORM, 8'h29);
        end
        for (int v = 0; v < NV; v++) begin
            reg_write(2'(v), WAVEFORM, 8'h21);
        end
        repeat (7) @(posedge clk);
        for (int v = 0; v < NV; v++) begin
            reg_write(2'(v), FREQ_HI, 8'h00);
        end
        // Every voice parked at full sustain gives a constant sample
        n = 0;
        while (n < T5_MAX_CYC && !(m_st[0].env_state == ENV_DECAY &&
               m_st[1].env_state == ENV_DECAY && m_st[2].env_state == ENV_DECAY)) begin
            @(negedge clk);
            n++;
        end
        repeat (256) @(negedge clk);
        high = 0;
        repeat (256) begin
            @(negedge clk);
            if (pwm) high++;
        end
        if (n >= T5_MAX_CYC) begin
            err_cnt++;
            $display("Envelopes never settled, so the PWM duty was not measured");
        end else if (high != int'(m_sample)) begin
            err_cnt++;
            $display("[ERROR] %0t: pwm high cycles expected %0d, seen %0d", $time, m_sample, high);
        end
        finish_test("pwm duty");

        $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #(TOTAL_CYC * 8);
        $display("Run timed out after %0d clock cycles without finishing", TOTAL_CYC);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/sid_pkg.sv
rtl/sid_reg_bank.sv
rtl/sid_envelope.sv
rtl/sid_voice_engine.sv
rtl/sid_mixer.sv
rtl/sid_pwm.sv
rtl/sid_top.sv
tests/sid_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SID testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module sid_tb -f src.f \
    && ./obj_dir/Vsid_tb | tee /dev/stderr | grep -qF "All tests passed!" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
